// ==== design/fifo_params.svh ====
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// sizes of the byte FIFO and its register block
// depth must stay a power of two so the pointers wrap on their own

`define FIFO_WIDTH 8   // bits in one data word
`define FIFO_DEPTH 16  // number of storage entries
`define FIFO_PTR_W 4   // log2 of the depth
`define FIFO_CNT_W 5   // one bit more than the pointer so a full FIFO fits
`define FIFO_ERR_W 8   // overflow and underflow counters saturate at all ones

`endif

// ==== design/fifo_pkg.sv ====
`include "fifo_params.svh"

package fifo_pkg;

   typedef logic [`FIFO_WIDTH-1:0] data_t;      // one word as stored in the FIFO
   typedef logic [`FIFO_CNT_W-1:0] count_t;     // fill level from zero up to the full depth
   typedef logic [`FIFO_ERR_W-1:0] err_cnt_t;   // refusal counters and register data width
   typedef logic [1:0]             reg_addr_t;  // four registers in the config space

   // everything the register block needs to know about the FIFO
   typedef struct packed {
      count_t level;         // registered fill count
      logic   push_refused;  // wr_en seen while full this cycle
      logic   pop_refused;   // rd_en seen while empty this cycle
   } fifo_status_t;

   // programmable fill thresholds held in the register block
   typedef struct packed {
      count_t af_level;  // almost_full asserts at or above this level
      count_t ae_level;  // almost_empty asserts at or below this level
   } fifo_cfg_t;

endpackage

// ==== design/sync_fifo.sv ====
`include "fifo_params.svh"

module sync_fifo
   import fifo_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         wr_en,    // push request from the writer
   input  data_t        wr_data,
   input  logic         rd_en,    // pop request from the reader
   output data_t        rd_data,  // head word shown whenever not empty
   output logic         full,
   output logic         empty,
   output fifo_status_t status    // level and refusal pulses for the register block
);

   typedef logic [`FIFO_PTR_W-1:0] ptr_t;

   localparam count_t DEPTH_CNT = count_t'(`FIFO_DEPTH);  // level that means full

   data_t  mem [`FIFO_DEPTH];  // storage array without reset
   ptr_t   wr_ptr;             // next slot to be written
   ptr_t   rd_ptr;             // slot holding the head word
   count_t level;              // number of words currently stored
   count_t next_level;         // level after this edge
   logic   valid_wr;           // push that actually happens at this edge
   logic   valid_rd;           // pop that actually happens at this edge

   // a strobe only counts when the flag allows it
   // this also resolves the push and pop pair at the empty and full corners
   assign valid_wr = wr_en & ~full;
   assign valid_rd = rd_en & ~empty;

   // fall-through read port shows the word at the read pointer
   assign rd_data = mem[rd_ptr];

   always_comb begin
      next_level = level;                        // push with pop or neither leaves it as is
      case ({valid_wr, valid_rd})
         2'b10:   next_level = level + count_t'(1);  // push only
         2'b01:   next_level = level - count_t'(1);  // pop only
         default: next_level = level;
      endcase
   end

   // words land in the array on every accepted push
   always_ff @(posedge clk) begin
      if (valid_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
         full   <= 1'b0;
         empty  <= 1'b1;  // an idle FIFO starts out empty
      end else begin
         if (valid_wr) begin
            wr_ptr <= wr_ptr + ptr_t'(1);  // wraps at the depth
         end
         if (valid_rd) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
         level <= next_level;
         full  <= (next_level == DEPTH_CNT);  // flags follow the new level with one cycle latency
         empty <= (next_level == '0);
      end
   end

   // refusals are combinational pulses that last for the cycle of the bad strobe
   always_comb begin
      status.level        = level;
      status.push_refused = wr_en & full;
      status.pop_refused  = rd_en & empty;
   end

endmodule

// ==== design/fifo_regs.sv ====
`include "fifo_params.svh"

module fifo_regs
   import fifo_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  fifo_status_t status,        // level and refusal pulses from the FIFO
   input  logic         cfg_wr,        // register write strobe
   input  reg_addr_t    cfg_addr,      // selects both the write target and the read-back
   input  err_cnt_t     cfg_wdata,
   output err_cnt_t     cfg_rdata,     // combinational read-back of the addressed register
   output logic         almost_full,
   output logic         almost_empty
);

   localparam reg_addr_t ADDR_AF    = 2'd0;  // almost-full threshold
   localparam reg_addr_t ADDR_AE    = 2'd1;  // almost-empty threshold
   localparam reg_addr_t ADDR_OVER  = 2'd2;  // overflow count which clears on write
   localparam reg_addr_t ADDR_UNDER = 2'd3;  // underflow count which clears on write

   localparam count_t   AF_RESET = count_t'(`FIFO_DEPTH - 2);  // two slots short of full
   localparam count_t   AE_RESET = count_t'(2);
   localparam err_cnt_t ERR_MAX  = '1;                         // counters stop here

   fifo_cfg_t cfg_q;          // both thresholds
   err_cnt_t  overflow_cnt;   // pushes dropped because the FIFO was full
   err_cnt_t  underflow_cnt;  // pops refused because the FIFO was empty
   logic      wr_af;          // decoded write strobes
   logic      wr_ae;
   logic      clr_over;
   logic      clr_under;

   assign wr_af     = cfg_wr && (cfg_addr == ADDR_AF);
   assign wr_ae     = cfg_wr && (cfg_addr == ADDR_AE);
   assign clr_over  = cfg_wr && (cfg_addr == ADDR_OVER);   // the write data is ignored here
   assign clr_under = cfg_wr && (cfg_addr == ADDR_UNDER);

   // threshold registers take the low bits of the write data
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_q.af_level <= AF_RESET;
         cfg_q.ae_level <= AE_RESET;
      end else begin
         if (wr_af) begin
            cfg_q.af_level <= count_t'(cfg_wdata);
         end
         if (wr_ae) begin
            cfg_q.ae_level <= count_t'(cfg_wdata);
         end
      end
   end

   // a clear at the same edge as a refusal wins over the increment
   always_ff @(posedge clk) begin
      if (reset) begin
         overflow_cnt <= '0;
      end else if (clr_over) begin
         overflow_cnt <= '0;
      end else if (status.push_refused && (overflow_cnt != ERR_MAX)) begin
         overflow_cnt <= overflow_cnt + err_cnt_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         underflow_cnt <= '0;
      end else if (clr_under) begin
         underflow_cnt <= '0;
      end else if (status.pop_refused && (underflow_cnt != ERR_MAX)) begin
         underflow_cnt <= underflow_cnt + err_cnt_t'(1);
      end
   end

   // thresholds read back zero-extended to the register width
   always_comb begin
      case (cfg_addr)
         ADDR_AF:   cfg_rdata = err_cnt_t'(cfg_q.af_level);
         ADDR_AE:   cfg_rdata = err_cnt_t'(cfg_q.ae_level);
         ADDR_OVER: cfg_rdata = overflow_cnt;
         default:   cfg_rdata = underflow_cnt;
      endcase
   end

   // both levels compare the registered fill count so they move with full and empty
   assign almost_full  = (status.level >= cfg_q.af_level);
   assign almost_empty = (status.level <= cfg_q.ae_level);

endmodule

// ==== design/fifo_top.sv ====
module fifo_top
   import fifo_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      wr_en,         // write side of the FIFO
   input  data_t     wr_data,
   input  logic      rd_en,         // read side of the FIFO
   output data_t     rd_data,
   output logic      full,
   output logic      empty,
   input  logic      cfg_wr,        // register port
   input  reg_addr_t cfg_addr,
   input  err_cnt_t  cfg_wdata,
   output err_cnt_t  cfg_rdata,
   output logic      almost_full,   // threshold levels from the register block
   output logic      almost_empty
);

   fifo_status_t status;  // fill level and refusal pulses passed between the two blocks

   // storage, pointers and the full and empty flags
   sync_fifo u_fifo (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_data (rd_data),
      .full    (full),
      .empty   (empty),
      .status  (status)
   );

   // thresholds and error counters that watch the FIFO status
   fifo_regs u_regs (
      .clk          (clk),
      .reset        (reset),
      .status       (status),
      .cfg_wr       (cfg_wr),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .cfg_rdata    (cfg_rdata),
      .almost_full  (almost_full),
      .almost_empty (almost_empty)
   );

endmodule

// ==== tests/fifo_checker.sv ====
`include "fifo_params.svh"

module fifo_checker
   import fifo_pkg::*;
(
   input logic   clk,
   input logic   reset,
   input logic   valid_wr,  // qualified push inside the FIFO
   input logic   valid_rd,  // qualified pop inside the FIFO
   input logic   full,
   input logic   empty,
   input count_t level      // registered fill count
);

   timeunit 1ns;
   timeprecision 1ps;

   // a push must never get past a FIFO that already holds its full depth
   assert property (@(posedge clk) disable iff (reset)
                    !(valid_wr && (level == count_t'(`FIFO_DEPTH))))
      else $error("push accepted while the FIFO was full");

   // a pop must never get past a FIFO that holds no words
   assert property (@(posedge clk) disable iff (reset)
                    !(valid_rd && (level == '0)))
      else $error("pop accepted while the FIFO was empty");

   assert property (@(posedge clk) disable iff (reset) !(full && empty))
      else $error("full and empty are high together");

   // the count has one spare bit so an overrun would show up here
   assert property (@(posedge clk) disable iff (reset) level <= count_t'(`FIFO_DEPTH))
      else $error("fill level went past the FIFO depth");

endmodule

// ==== tests/fifo_monitor.sv ====
module fifo_monitor
   import fifo_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      wr_en,        // DUT inputs as the DUT sees them
   input  data_t     wr_data,
   input  logic      rd_en,
   input  logic      cfg_wr,
   input  reg_addr_t cfg_addr,
   input  err_cnt_t  cfg_wdata,
   input  data_t     rd_data,      // DUT outputs
   input  logic      full,
   input  logic      empty,
   input  logic      almost_full,
   input  logic      almost_empty,
   input  err_cnt_t  cfg_rdata,
   input  int        test_num,     // test that the current cycle belongs to
   input  logic [5:0] exp_care,    // rd_data, full, empty, almost_full, almost_empty, cfg_rdata
   input  data_t     exp_rd,
   input  logic [3:0] exp_flags,   // full, empty, almost_full, almost_empty
   input  err_cnt_t  exp_rdata,
   input  logic      done,         // stimulus is over
   output int        error_count,
   output int        test_count,
   output logic      finished
);

   timeunit 1ns;
   timeprecision 1ps;

   data_t    model_q[$];   // reference copy of the FIFO contents
   count_t   af_thr;       // reference thresholds
   count_t   ae_thr;
   err_cnt_t over_cnt;     // reference refusal counters
   err_cnt_t under_cnt;
   int       cur_test = 0;
   int       test_errors = 0;
   logic     push_ok;
   logic     pop_ok;

   initial begin
      error_count = 0;
      test_count  = 0;
      finished    = 1'b0;
   end

   task automatic compare(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
      if (expected !== actual) begin
         $display("error %s expected 0x%h actual 0x%h in test %0d", name, expected, actual,
                  cur_test);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic close_test();
      if (cur_test != 0) begin
         $display("test %0d finished with %0d errors", cur_test, test_errors);
         test_count++;
      end
      test_errors = 0;
   endtask

   // what the register port should read back for an address
   function automatic err_cnt_t reg_value(input reg_addr_t addr);
      case (addr)
         2'd0:    return err_cnt_t'(af_thr);
         2'd1:    return err_cnt_t'(ae_thr);
         2'd2:    return over_cnt;
         default: return under_cnt;
      endcase
   endfunction

   // outputs are stable at the falling edge, halfway between two driven edges
   always @(negedge clk) begin
      if (reset) begin
         model_q.delete();   // reset values of the reference model
         af_thr    = 5'd14;
         ae_thr    = 5'd2;
         over_cnt  = '0;
         under_cnt = '0;
      end else if (!finished) begin
         if (test_num != cur_test) begin
            close_test();
            cur_test = test_num;
         end
         if (exp_care[5]) compare("rd_data", exp_rd, rd_data);   // expectations from the stim file
         if (exp_care[4]) compare("full", 8'(exp_flags[3]), 8'(full));
         if (exp_care[3]) compare("empty", 8'(exp_flags[2]), 8'(empty));
         if (exp_care[2]) compare("almost_full", 8'(exp_flags[1]), 8'(almost_full));
         if (exp_care[1]) compare("almost_empty", 8'(exp_flags[0]), 8'(almost_empty));
         if (exp_care[0]) compare("cfg_rdata", exp_rdata, cfg_rdata);
         compare("empty", 8'(model_q.size() == 0), 8'(empty));   // model checks on every cycle
         compare("full", 8'(model_q.size() == 16), 8'(full));
         if (model_q.size() != 0) compare("rd_data", model_q[0], rd_data);
         compare("almost_full", 8'(model_q.size() >= int'(af_thr)), 8'(almost_full));
         compare("almost_empty", 8'(model_q.size() <= int'(ae_thr)), 8'(almost_empty));
         compare("cfg_rdata", reg_value(cfg_addr), cfg_rdata);
         if (done) begin
            close_test();
            finished = 1'b1;
         end else begin
            push_ok = wr_en && (model_q.size() < 16);   // inputs that the next edge will take
            pop_ok  = rd_en && (model_q.size() > 0);
            if (cfg_wr && cfg_addr == 2'd2) over_cnt = '0;   // clear beats the increment
            else if (wr_en && !push_ok && over_cnt != 8'hff) over_cnt = over_cnt + 8'd1;
            if (cfg_wr && cfg_addr == 2'd3) under_cnt = '0;
            else if (rd_en && !pop_ok && under_cnt != 8'hff) under_cnt = under_cnt + 8'd1;
            if (cfg_wr && cfg_addr == 2'd0) af_thr = count_t'(cfg_wdata);
            if (cfg_wr && cfg_addr == 2'd1) ae_thr = count_t'(cfg_wdata);
            if (pop_ok) void'(model_q.pop_front());
            if (push_ok) model_q.push_back(wr_data);
         end
      end
   end

endmodule

// ==== tests/fifo_tb.sv ====
module fifo_tb
   import fifo_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_LINES = 1000;   // longest stim file that is accepted
   localparam int RAND_CYCLES = 400;

   logic       clk;
   logic       reset;
   logic       wr_en;
   data_t      wr_data;
   logic       rd_en;
   data_t      rd_data;
   logic       full;
   logic       empty;
   logic       cfg_wr;
   reg_addr_t  cfg_addr;
   err_cnt_t   cfg_wdata;
   err_cnt_t   cfg_rdata;
   logic       almost_full;
   logic       almost_empty;
   int         test_num;
   logic [5:0] exp_care;
   data_t      exp_rd;
   logic [3:0] exp_flags;
   err_cnt_t   exp_rdata;
   logic       done;
   int         error_count;
   int         test_count;
   logic       finished;
   logic       fail_flag;

   fifo_top u_dut (.*);

   fifo_monitor u_mon (.*);

   bind sync_fifo fifo_checker u_chk (
      .clk      (clk),
      .reset    (reset),
      .valid_wr (valid_wr),
      .valid_rd (valid_rd),
      .full     (full),
      .empty    (empty),
      .level    (level)
   );

   always #50 clk = ~clk;   // 100 ns period

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // a dash means the column is not checked
   function automatic logic parse_tok(input string tok, output logic [7:0] val);
      val = '0;
      if (tok == "-") return 1'b0;
      void'($sscanf(tok, "%h", val));
      return 1'b1;
   endfunction

   task automatic apply_line(input int tnum, input int reps, input logic [7:0] col[6],
                             input logic [7:0] exp_v[6], input logic [5:0] care);
      for (int i = 0; i < reps; i++) begin
         @(posedge clk);
         wr_en     <= col[0][0];
         wr_data   <= col[1] + data_t'(i);   // repeated pushes write a rising sequence
         rd_en     <= col[2][0];
         cfg_wr    <= col[3][0];
         cfg_addr  <= reg_addr_t'(col[4]);
         cfg_wdata <= col[5];
         test_num  <= tnum;
         exp_care  <= (i == 0) ? care : 6'b0;   // only the first cycle of a line has expectations
         exp_rd    <= exp_v[0];
         exp_flags <= {exp_v[1][0], exp_v[2][0], exp_v[3][0], exp_v[4][0]};
         exp_rdata <= exp_v[5];
      end
   endtask

   initial begin
      int          fd;
      int          lines;
      int          n;
      int          tnum;
      int          reps;
      int          waited;
      string       line;
      string       tok[6];
      logic [7:0]  col[6];
      logic [7:0]  exp_v[6];
      logic [5:0]  care;
      logic [31:0] rnd;
      clk       = 1'b0;
      reset     = 1'b1;
      wr_en     = 1'b0;
      wr_data   = '0;
      rd_en     = 1'b0;
      cfg_wr    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      test_num  = 0;
      exp_care  = '0;
      exp_rd    = '0;
      exp_flags = '0;
      exp_rdata = '0;
      done      = 1'b0;
      fail_flag = 1'b0;
      rnd       = 32'd23174;
      waited    = 0;
      while (waited < 4) begin   // reset held for four cycles
         @(posedge clk);
         waited++;
      end
      reset <= 1'b0;
      fd = $fopen("tests/fifo_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stim file tests/fifo_stim.txt");
         fail_flag = 1'b1;
      end else begin
         lines = 0;
         while (!$feof(fd) && lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            lines++;
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%d %d %h %h %h %h %h %h %s %s %s %s %s %s", tnum, reps,
                        col[0], col[1], col[2], col[3], col[4], col[5],
                        tok[0], tok[1], tok[2], tok[3], tok[4], tok[5]);
            if (n != 14) begin
               $display("stim line %0d is malformed and was skipped", lines);
               fail_flag = 1'b1;
               continue;
            end
            for (int k = 0; k < 6; k++) care[5 - k] = parse_tok(tok[k], exp_v[k]);
            apply_line(tnum, reps, col, exp_v, care);
         end
         if (!$feof(fd)) begin
            $display("stim file did not end within %0d lines", MAX_LINES);
            fail_flag = 1'b1;
         end
         $fclose(fd);
      end
      // random traffic that only the reference model checks
      for (int c = 0; c < RAND_CYCLES; c++) begin
         rnd = xorshift32(rnd);
         @(posedge clk);
         wr_en     <= rnd[0];
         rd_en     <= rnd[1];
         cfg_wr    <= 1'b0;
         cfg_addr  <= rnd[3:2];
         wr_data   <= rnd[15:8];
         test_num  <= 6;
         exp_care  <= '0;
      end
      @(posedge clk);
      wr_en <= 1'b0;
      rd_en <= 1'b0;
      done  <= 1'b1;
      waited = 0;
      while (!finished && waited < 10) begin   // the monitor closes the last test
         @(posedge clk);
         waited++;
      end
      if (!finished) begin
         $display("monitor did not report the end of the run within 10 cycles");
         fail_flag = 1'b1;
      end
      $display("%0d tests run, %0d errors", test_count, error_count);
      if (fail_flag || error_count != 0) begin
         $display("Test failed");
      end else begin
         $display("Test passed");
      end
      $finish;
   end

endmodule

// ==== tests/fifo_stim.txt ====
# test reps wr_en wr_data rd_en cfg_wr cfg_addr cfg_wdata | rd_data full empty almost_full almost_empty cfg_rdata
# inputs in hex, wr_data counts up on repeats, expected values hold in the first cycle of a line, - is don't care
1 1 0 00 0 0 0 00 - 0 1 0 1 0e
1 1 0 00 0 0 1 00 - 0 1 0 1 02
1 1 0 00 0 0 2 00 - 0 1 0 1 00
1 1 0 00 0 0 3 00 - 0 1 0 1 00
2 16 1 a0 0 0 0 00 - 0 1 0 1 0e
2 1 0 00 1 0 0 00 a0 1 0 1 0 0e
2 15 0 00 1 0 0 00 a1 0 0 1 0 0e
2 1 0 00 0 0 0 00 - 0 1 0 1 0e
3 3 0 00 1 0 3 00 - 0 1 0 1 00
3 1 0 00 0 0 3 00 - 0 1 0 1 03
3 1 0 00 0 1 3 55 - 0 1 0 1 03
3 1 0 00 0 0 3 00 - 0 1 0 1 00
3 16 1 10 0 0 2 00 - 0 1 0 1 00
3 2 1 ee 0 0 2 00 10 1 0 1 0 00
3 1 0 00 0 0 2 00 10 1 0 1 0 02
3 1 0 00 0 1 2 00 10 1 0 1 0 02
3 1 0 00 0 0 2 00 10 1 0 1 0 00
4 1 1 c0 1 0 0 00 10 1 0 1 0 0e
4 7 0 00 1 0 0 00 11 0 0 1 0 0e
4 4 1 d0 1 0 0 00 18 0 0 0 0 0e
4 1 0 00 0 0 0 00 1c 0 0 0 0 0e
4 8 0 00 1 0 0 00 1c 0 0 0 0 0e
4 1 1 e5 1 0 0 00 - 0 1 0 1 0e
4 1 0 00 0 0 0 00 e5 0 0 0 1 0e
4 1 0 00 1 0 0 00 e5 0 0 0 1 0e
5 1 0 00 0 1 0 05 - 0 1 0 1 0e
5 1 0 00 0 1 1 03 - 0 1 0 1 02
5 1 0 00 0 0 0 00 - 0 1 0 1 05
5 3 1 40 0 0 1 00 - 0 1 0 1 03
5 1 1 43 0 0 1 00 40 0 0 0 1 03
5 1 1 44 0 0 1 00 40 0 0 0 0 03
5 1 0 00 0 0 1 00 40 0 0 1 0 03
5 1 0 00 1 0 1 00 40 0 0 1 0 03
5 1 0 00 0 0 1 00 41 0 0 0 0 03
5 4 0 00 1 0 0 00 41 0 0 0 0 05

// ==== all.f ====
+incdir+design
design/fifo_pkg.sv
design/sync_fifo.sv
design/fifo_regs.sv
design/fifo_top.sv
tests/fifo_checker.sv
tests/fifo_monitor.sv
tests/fifo_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module fifo_tb -o fifo_sim
./obj_dir/fifo_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
   exit 0
fi
exit 1
